// ==== counter_timer.sv ====
// down counting timer
`timescale 1ns/1ns

module counter_timer import soc_periph_pkg::*; #(
  parameter int TIMER_W = 32
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  output logic      irq_o,
  periph_bus_if.dev bus
);

  logic               r_en, r_oneshot, r_irqen;
  logic [TIMER_W-1:0] r_val, r_dat;
  logic               r_ready;
  word_t              r_rdata;
  word_t              s_rd_word;
  word_t              s_val_m, s_dat_m;
  logic               s_acc, s_cfg_we, s_val_we, s_dat_we;
  logic               s_zero;

  if (TIMER_W < 8 || TIMER_W > 32) begin : g_width_check
    $error("counter_timer: TIMER_W must be 8 to 32");
  end

  assign s_acc    = bus.valid && !r_ready;
  assign s_cfg_we = s_acc && bus.off == OFF_TIM_CFG && bus.wstrb[0];
  assign s_val_we = s_acc && bus.off == OFF_TIM_VAL && |bus.wstrb;
  assign s_dat_we = s_acc && bus.off == OFF_TIM_DAT && |bus.wstrb;
  assign s_val_m  = strb_merge(word_t'(r_val), bus.wdata, bus.wstrb);
  assign s_dat_m  = strb_merge(word_t'(r_dat), bus.wdata, bus.wstrb);
  assign s_zero   = r_val == '0;

  // one-shot holds irq once stopped, periodic pulses on reload
  assign irq_o = r_irqen && s_zero && (r_oneshot ? !r_en : r_en);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_en      <= 1'b0;
      r_oneshot <= 1'b0;
      r_irqen   <= 1'b0;
      r_val     <= '0;
      r_dat     <= '0;
      r_ready   <= 1'b0;
    end else begin
      r_ready <= s_acc;
      if (s_cfg_we) begin
        r_en      <= bus.wdata[TIM_CFG_EN];
        r_oneshot <= bus.wdata[TIM_CFG_ONESHOT];
        r_irqen   <= bus.wdata[TIM_CFG_IRQEN];
      end else if (r_en && r_oneshot && s_zero) begin
        r_en <= 1'b0;
      end
      if (s_val_we) begin
        r_val <= s_val_m[TIMER_W-1:0];
      end else if (r_en) begin
        if (!s_zero)         r_val <= r_val - 1'b1;
        else if (!r_oneshot) r_val <= r_dat;
      end
      if (s_dat_we) r_dat <= s_dat_m[TIMER_W-1:0];
    end
  end

  always_comb begin
    case (bus.off)
      OFF_TIM_CFG: s_rd_word = {29'd0, r_irqen, r_oneshot, r_en};
      OFF_TIM_VAL: s_rd_word = word_t'(r_val);
      OFF_TIM_DAT: s_rd_word = word_t'(r_dat);
      default:     s_rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (s_acc) r_rdata <= s_rd_word;
  end

  assign bus.ready = r_ready;
  assign bus.rdata = r_rdata;

  a_oneshot_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (r_oneshot && s_zero && !s_val_we && !s_cfg_we) |=> r_val != '1);

endmodule

// ==== flist.f ====
+incdir+.
soc_periph_pkg.sv
periph_bus_if.sv
periph_bus_fabric.sv
sys_ctrl_regs.sv
counter_timer.sv
soc_periph_top.sv
tb_soc_periph.sv

// ==== periph_bus_fabric.sv ====
// memory bus decode and merge
`timescale 1ns/1ns

module periph_bus_fabric import soc_periph_pkg::*; #(
  parameter int MEM_WORDS = 32768
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  mem_valid_i,
  output logic                  mem_ready_o,
  input  word_t                 mem_addr_i,
  input  word_t                 mem_wdata_i,
  input  strb_t                 mem_wstrb_i,
  output word_t                 mem_rdata_o,
  output strb_t                 ram_wstrb_o,
  output logic [RAM_ADDR_W-1:0] ram_addr_o,
  output word_t                 ram_wdata_o,
  input  word_t                 ram_rdata_i,
  periph_bus_if.host            sys_bus,
  periph_bus_if.host            tim0_bus,
  periph_bus_if.host            tim1_bus
);

  localparam word_t RAM_LIMIT = word_t'(4 * MEM_WORDS);

  reg_off_t s_off;
  logic     s_mmio, s_ram_sel, s_sys_sel, s_tim0_sel, s_tim1_sel, s_unm_sel;
  logic     s_ram_req, s_unm_req;
  logic     r_ram_ready, r_unm_ready;

  // window decode on address only
  assign s_off      = mem_addr_i[7:0];
  assign s_mmio     = mem_addr_i[31:8] == MMIO_BASE[31:8];
  assign s_ram_sel  = mem_addr_i < RAM_LIMIT;
  assign s_sys_sel  = s_mmio && s_off < TIM0_BASE;
  assign s_tim0_sel = s_mmio && s_off >= TIM0_BASE && s_off < TIM1_BASE;
  assign s_tim1_sel = s_mmio && s_off >= TIM1_BASE && s_off < TIM1_BASE + TIM_WIN;
  assign s_unm_sel  = !(s_ram_sel || s_sys_sel || s_tim0_sel || s_tim1_sel);

  assign s_ram_req = mem_valid_i && s_ram_sel && !r_ram_ready;
  assign s_unm_req = mem_valid_i && s_unm_sel && !r_unm_ready;

  // sram strobes only in the cycle before ready
  assign ram_wstrb_o = s_ram_req ? mem_wstrb_i : '0;
  assign ram_addr_o  = mem_addr_i[RAM_ADDR_W+1:2];
  assign ram_wdata_o = mem_wdata_i;

  assign sys_bus.valid  = mem_valid_i && s_sys_sel;
  assign sys_bus.off    = s_off;
  assign sys_bus.wdata  = mem_wdata_i;
  assign sys_bus.wstrb  = mem_wstrb_i;
  assign tim0_bus.valid = mem_valid_i && s_tim0_sel;
  assign tim0_bus.off   = s_off - TIM0_BASE;
  assign tim0_bus.wdata = mem_wdata_i;
  assign tim0_bus.wstrb = mem_wstrb_i;
  assign tim1_bus.valid = mem_valid_i && s_tim1_sel;
  assign tim1_bus.off   = s_off - TIM1_BASE;
  assign tim1_bus.wdata = mem_wdata_i;
  assign tim1_bus.wstrb = mem_wstrb_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_ram_ready <= 1'b0;
      r_unm_ready <= 1'b0;
    end else begin
      r_ram_ready <= s_ram_req;
      r_unm_ready <= s_unm_req;
    end
  end

  assign mem_ready_o = r_ram_ready || r_unm_ready || sys_bus.ready
                       || tim0_bus.ready || tim1_bus.ready;

  // unmapped reply falls through to zero
  always_comb begin
    if (r_ram_ready)         mem_rdata_o = ram_rdata_i;
    else if (sys_bus.ready)  mem_rdata_o = sys_bus.rdata;
    else if (tim0_bus.ready) mem_rdata_o = tim0_bus.rdata;
    else if (tim1_bus.ready) mem_rdata_o = tim1_bus.rdata;
    else                     mem_rdata_o = '0;
  end

  a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({mem_valid_i && s_ram_sel, sys_bus.valid, tim0_bus.valid,
              tim1_bus.valid, mem_valid_i && s_unm_sel}));

  a_ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_ready_o) |-> $past(mem_valid_i));

endmodule

// ==== periph_bus_if.sv ====
// internal register bus
`timescale 1ns/1ns

interface periph_bus_if import soc_periph_pkg::*; ();

  logic     valid;
  logic     ready;
  reg_off_t off;
  word_t    wdata;
  strb_t    wstrb;
  word_t    rdata;

  // fabric side
  modport host (
    output valid,
    output off,
    output wdata,
    output wstrb,
    input  ready,
    input  rdata
  );

  // register slave side, decodes off only
  modport dev (
    input  valid,
    input  off,
    input  wdata,
    input  wstrb,
    output ready,
    output rdata
  );

endinterface

// ==== soc_periph_pkg.sv ====
// soc peripheral definitions
package soc_periph_pkg;

  typedef logic [31:0] word_t;
  typedef logic [3:0]  strb_t;
  typedef logic [15:0] gpio_t;
  typedef logic [7:0]  reg_off_t;
  typedef logic [3:0]  irq_vec_t;

  typedef enum logic [1:0] {NONE, D1, D2, D3} pad_dest_t;
  typedef enum logic [1:0] {OFF, S1, S2, S3} irq_src_t;

  // pad and identity widths
  localparam int RAM_ADDR_W = 15;
  localparam int MFGR_ID_W  = 12;
  localparam int PROD_ID_W  = 8;
  localparam int MASK_REV_W = 4;

  localparam word_t MMIO_BASE = 32'h0300_0000;

  // system register window
  localparam reg_off_t OFF_GPIO      = 8'h00;
  localparam reg_off_t OFF_GPIO_OEB  = 8'h04;
  localparam reg_off_t OFF_GPIO_PU   = 8'h08;
  localparam reg_off_t OFF_GPIO_PD   = 8'h0C;
  localparam reg_off_t OFF_MFGR_ID   = 8'h24;
  localparam reg_off_t OFF_PROD_ID   = 8'h28;
  localparam reg_off_t OFF_MASK_REV  = 8'h2C;
  localparam reg_off_t OFF_CLK_SEL   = 8'h30;
  localparam reg_off_t OFF_PLL_DEST  = 8'h38;
  localparam reg_off_t OFF_TRAP_DEST = 8'h3C;
  localparam reg_off_t OFF_IRQ7_SRC  = 8'h40;
  localparam reg_off_t OFF_IRQ8_SRC  = 8'h44;

  // timer windows, three words each
  localparam reg_off_t TIM0_BASE   = 8'h5C;
  localparam reg_off_t TIM1_BASE   = 8'h68;
  localparam reg_off_t TIM_WIN     = 8'h0C;
  localparam reg_off_t OFF_TIM_CFG = 8'h0;
  localparam reg_off_t OFF_TIM_VAL = 8'h4;
  localparam reg_off_t OFF_TIM_DAT = 8'h8;

  localparam int TIM_CFG_EN      = 0;
  localparam int TIM_CFG_ONESHOT = 1;
  localparam int TIM_CFG_IRQEN   = 2;

  // replace the bytes whose strobe is set
  function automatic word_t strb_merge(word_t old_w, word_t new_w, strb_t strb);
    word_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

endpackage

// ==== soc_periph_top.sv ====
// soc peripheral subsystem
`timescale 1ns/1ns

module soc_periph_top import soc_periph_pkg::*; #(
  parameter int MEM_WORDS = 32768,
  parameter int TIMER_W   = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // native memory bus
  input  logic                  mem_valid_i,
  output logic                  mem_ready_o,
  input  word_t                 mem_addr_i,
  input  word_t                 mem_wdata_i,
  input  strb_t                 mem_wstrb_i,
  output word_t                 mem_rdata_o,
  // external sram
  output strb_t                 ram_wstrb_o,
  output logic [RAM_ADDR_W-1:0] ram_addr_o,
  output word_t                 ram_wdata_o,
  input  word_t                 ram_rdata_i,
  // pads
  output gpio_t                 gpio_out_o,
  input  gpio_t                 gpio_in_i,
  output gpio_t                 gpio_outenb_o,
  output gpio_t                 gpio_pullupb_o,
  output gpio_t                 gpio_pulldownb_o,
  input  logic                  trap_i,
  input  logic                  clk_ext_sel_i,
  input  logic [MFGR_ID_W-1:0]  mfgr_id_i,
  input  logic [PROD_ID_W-1:0]  prod_id_i,
  input  logic [MASK_REV_W-1:0] mask_rev_i,
  output irq_vec_t              irq_o
);

  logic [1:0] s_irq_sel;
  logic       s_irq_tim0;
  logic       s_irq_tim1;

  periph_bus_if sys_bus ();
  periph_bus_if tim0_bus ();
  periph_bus_if tim1_bus ();

  assign irq_o = {s_irq_sel, s_irq_tim1, s_irq_tim0};

  periph_bus_fabric #(
    .MEM_WORDS(MEM_WORDS)
  ) u_fabric (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid_i),
    .mem_ready_o (mem_ready_o),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wstrb_i (mem_wstrb_i),
    .mem_rdata_o (mem_rdata_o),
    .ram_wstrb_o (ram_wstrb_o),
    .ram_addr_o  (ram_addr_o),
    .ram_wdata_o (ram_wdata_o),
    .ram_rdata_i (ram_rdata_i),
    .sys_bus     (sys_bus.host),
    .tim0_bus    (tim0_bus.host),
    .tim1_bus    (tim1_bus.host)
  );

  sys_ctrl_regs u_sys_regs (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .gpio_in_i        (gpio_in_i),
    .trap_i           (trap_i),
    .clk_ext_sel_i    (clk_ext_sel_i),
    .mfgr_id_i        (mfgr_id_i),
    .prod_id_i        (prod_id_i),
    .mask_rev_i       (mask_rev_i),
    .gpio_out_o       (gpio_out_o),
    .gpio_outenb_o    (gpio_outenb_o),
    .gpio_pullupb_o   (gpio_pullupb_o),
    .gpio_pulldownb_o (gpio_pulldownb_o),
    .irq_sel_o        (s_irq_sel),
    .bus              (sys_bus.dev)
  );

  counter_timer #(
    .TIMER_W(TIMER_W)
  ) u_tim0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .irq_o   (s_irq_tim0),
    .bus     (tim0_bus.dev)
  );

  counter_timer #(
    .TIMER_W(TIMER_W)
  ) u_tim1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .irq_o   (s_irq_tim1),
    .bus     (tim1_bus.dev)
  );

endmodule

// ==== sys_ctrl_regs.sv ====
// system control register bank
`timescale 1ns/1ns

module sys_ctrl_regs import soc_periph_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  gpio_t                 gpio_in_i,
  input  logic                  trap_i,
  input  logic                  clk_ext_sel_i,
  input  logic [MFGR_ID_W-1:0]  mfgr_id_i,
  input  logic [PROD_ID_W-1:0]  prod_id_i,
  input  logic [MASK_REV_W-1:0] mask_rev_i,
  output gpio_t                 gpio_out_o,
  output gpio_t                 gpio_outenb_o,
  output gpio_t                 gpio_pullupb_o,
  output gpio_t                 gpio_pulldownb_o,
  output logic [1:0]            irq_sel_o,
  periph_bus_if.dev             bus
);

  gpio_t     r_gpio, r_gpio_oeb, r_gpio_pu, r_gpio_pd;
  pad_dest_t r_pll_dest, r_trap_dest;
  irq_src_t  r_irq7_src, r_irq8_src;
  logic      r_ready;
  word_t     r_rdata;
  word_t     s_rd_word;
  gpio_t     s_out, s_oeb, s_pu, s_pd;
  logic      s_acc;

  function automatic logic pick_src(irq_src_t src, logic [2:0] pins);
    case (src)
      S1:      return pins[0];
      S2:      return pins[1];
      S3:      return pins[2];
      default: return 1'b0;
    endcase
  endfunction

  assign s_acc = bus.valid && !r_ready;

  // pad overrides, pll group is pins 8..10 and trap group 11..13
  always_comb begin
    s_out = r_gpio;
    s_oeb = r_gpio_oeb;
    s_pu  = r_gpio_pu;
    s_pd  = r_gpio_pd;
    if (r_pll_dest == D1) s_out[8] = clk_i;
    if (r_pll_dest == D2) s_out[9] = clk_i;
    case (r_trap_dest)
      D1:      s_out[11] = trap_i;
      D2:      s_out[12] = trap_i;
      D3:      s_out[13] = trap_i;
      default: ;
    endcase
    if (r_pll_dest != NONE) begin
      s_oeb[10:8] = '0;
      s_pu[10:8]  = '1;
      s_pd[10:8]  = '1;
    end
    if (r_trap_dest != NONE) begin
      s_oeb[13:11] = '0;
      s_pu[13:11]  = '1;
      s_pd[13:11]  = '1;
    end
  end

  assign gpio_out_o       = s_out;
  // outputs stay tristated while in reset
  assign gpio_outenb_o    = s_oeb | {16{~rst_n_i}};
  assign gpio_pullupb_o   = s_pu;
  assign gpio_pulldownb_o = s_pd;

  assign irq_sel_o[0] = pick_src(r_irq7_src, gpio_in_i[2:0]);
  assign irq_sel_o[1] = pick_src(r_irq8_src, gpio_in_i[5:3]);

  always_comb begin
    case (bus.off)
      OFF_GPIO:      s_rd_word = {gpio_out_o, gpio_in_i};
      OFF_GPIO_OEB:  s_rd_word = word_t'(r_gpio_oeb);
      OFF_GPIO_PU:   s_rd_word = word_t'(r_gpio_pu);
      OFF_GPIO_PD:   s_rd_word = word_t'(r_gpio_pd);
      OFF_MFGR_ID:   s_rd_word = word_t'(mfgr_id_i);
      OFF_PROD_ID:   s_rd_word = word_t'(prod_id_i);
      OFF_MASK_REV:  s_rd_word = word_t'(mask_rev_i);
      OFF_CLK_SEL:   s_rd_word = word_t'(clk_ext_sel_i);
      OFF_PLL_DEST:  s_rd_word = word_t'(r_pll_dest);
      OFF_TRAP_DEST: s_rd_word = word_t'(r_trap_dest);
      OFF_IRQ7_SRC:  s_rd_word = word_t'(r_irq7_src);
      OFF_IRQ8_SRC:  s_rd_word = word_t'(r_irq8_src);
      default:       s_rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_ready     <= 1'b0;
      r_gpio      <= '0;
      r_gpio_oeb  <= '1;
      r_gpio_pu   <= '0;
      r_gpio_pd   <= '0;
      r_pll_dest  <= NONE;
      r_trap_dest <= NONE;
      r_irq7_src  <= OFF;
      r_irq8_src  <= OFF;
    end else begin
      r_ready <= s_acc;
      if (s_acc) begin
        case (bus.off)
          OFF_GPIO:     r_gpio     <= gpio_t'(strb_merge(r_gpio, bus.wdata, bus.wstrb));
          OFF_GPIO_OEB: r_gpio_oeb <= gpio_t'(strb_merge(r_gpio_oeb, bus.wdata, bus.wstrb));
          OFF_GPIO_PU:  r_gpio_pu  <= gpio_t'(strb_merge(r_gpio_pu, bus.wdata, bus.wstrb));
          OFF_GPIO_PD:  r_gpio_pd  <= gpio_t'(strb_merge(r_gpio_pd, bus.wdata, bus.wstrb));
          OFF_PLL_DEST:  if (bus.wstrb[0]) r_pll_dest <= pad_dest_t'(bus.wdata[1:0]);
          OFF_TRAP_DEST: if (bus.wstrb[0]) r_trap_dest <= pad_dest_t'(bus.wdata[1:0]);
          OFF_IRQ7_SRC:  if (bus.wstrb[0]) r_irq7_src <= irq_src_t'(bus.wdata[1:0]);
          OFF_IRQ8_SRC:  if (bus.wstrb[0]) r_irq8_src <= irq_src_t'(bus.wdata[1:0]);
          default: ;
        endcase
      end
    end
  end

  // read data is the value before the write
  always_ff @(posedge clk_i) begin
    if (s_acc) r_rdata <= s_rd_word;
  end

  assign bus.ready = r_ready;
  assign bus.rdata = r_rdata;

  a_ready_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bus.ready |=> !bus.ready);

endmodule

// ==== tb_soc_periph_checks.svh ====
// reference model and compare tasks
`ifndef TB_SOC_PERIPH_CHECKS_SVH
`define TB_SOC_PERIPH_CHECKS_SVH

localparam int PAD_OUT = 0;
localparam int PAD_OEB = 1;
localparam int PAD_PU  = 2;
localparam int PAD_PD  = 3;

// initial ram content, every address bit counts
function automatic word_t fill_pattern(int idx);
  return (word_t'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_0000;
endfunction

function automatic word_t merge_bytes(word_t old_w, word_t wr_w, strb_t strb);
  word_t res;
  res = old_w;
  for (int b = 0; b < 4; b++) begin
    if (strb[b]) res[8*b +: 8] = wr_w[8*b +: 8];
  end
  return res;
endfunction

function automatic word_t expected_ram_word(int idx);
  return ram_shadow.exists(idx) ? ram_shadow[idx] : fill_pattern(idx);
endfunction

function automatic void note_ram_write(int idx, word_t data, strb_t strb);
  ram_shadow[idx] = merge_bytes(expected_ram_word(idx), data, strb);
endfunction

function automatic void reset_shadows();
  sh_gpio = '0;
  sh_oeb  = '1;
  sh_pu   = '0;
  sh_pd   = '0;
  sh_pll  = NONE;
  sh_trap = NONE;
  sh_irq7 = OFF;
  sh_irq8 = OFF;
endfunction

// only byte 0 matters for the selectors
function automatic void note_sys_write(reg_off_t off, word_t data, strb_t strb);
  case (off)
    OFF_GPIO:      sh_gpio = gpio_t'(merge_bytes(word_t'(sh_gpio), data, strb));
    OFF_GPIO_OEB:  sh_oeb = gpio_t'(merge_bytes(word_t'(sh_oeb), data, strb));
    OFF_GPIO_PU:   sh_pu = gpio_t'(merge_bytes(word_t'(sh_pu), data, strb));
    OFF_GPIO_PD:   sh_pd = gpio_t'(merge_bytes(word_t'(sh_pd), data, strb));
    OFF_PLL_DEST:  if (strb[0]) sh_pll = pad_dest_t'(data[1:0]);
    OFF_TRAP_DEST: if (strb[0]) sh_trap = pad_dest_t'(data[1:0]);
    OFF_IRQ7_SRC:  if (strb[0]) sh_irq7 = irq_src_t'(data[1:0]);
    OFF_IRQ8_SRC:  if (strb[0]) sh_irq8 = irq_src_t'(data[1:0]);
    default: ;
  endcase
endfunction

function automatic gpio_t pad_model(int kind, logic clk_lvl, logic trap_lvl);
  gpio_t out_v, oeb_v, pu_v, pd_v;
  out_v = sh_gpio;
  oeb_v = sh_oeb;
  pu_v  = sh_pu;
  pd_v  = sh_pd;
  if (sh_pll == D1) out_v[8] = clk_lvl;
  if (sh_pll == D2) out_v[9] = clk_lvl;
  if (sh_trap != NONE) out_v[10 + int'(sh_trap)] = trap_lvl;
  // an active override owns its three pins
  if (sh_pll != NONE) begin
    oeb_v[10:8] = 3'b000;
    pu_v[10:8]  = 3'b111;
    pd_v[10:8]  = 3'b111;
  end
  if (sh_trap != NONE) begin
    oeb_v[13:11] = 3'b000;
    pu_v[13:11]  = 3'b111;
    pd_v[13:11]  = 3'b111;
  end
  case (kind)
    PAD_OUT: return out_v;
    PAD_OEB: return oeb_v;
    PAD_PU:  return pu_v;
    default: return pd_v;
  endcase
endfunction

function automatic logic select_pin(irq_src_t src, logic [2:0] pins);
  return (src == OFF) ? 1'b0 : pins[int'(src) - 1];
endfunction

function automatic irq_vec_t irq_model(logic tim0_irq, logic tim1_irq);
  irq_vec_t v;
  v[0] = tim0_irq;
  v[1] = tim1_irq;
  v[2] = select_pin(sh_irq7, gpio_in[2:0]);
  v[3] = select_pin(sh_irq8, gpio_in[5:3]);
  return v;
endfunction

// gpio data read assumes no clock routed onto the pads
function automatic word_t sys_read_model(reg_off_t off);
  case (off)
    OFF_GPIO:      return {pad_model(PAD_OUT, 1'b0, trap), gpio_in};
    OFF_GPIO_OEB:  return word_t'(sh_oeb);
    OFF_GPIO_PU:   return word_t'(sh_pu);
    OFF_GPIO_PD:   return word_t'(sh_pd);
    OFF_MFGR_ID:   return word_t'(mfgr_id);
    OFF_PROD_ID:   return word_t'(prod_id);
    OFF_MASK_REV:  return word_t'(mask_rev);
    OFF_CLK_SEL:   return word_t'(clk_ext_sel);
    OFF_PLL_DEST:  return word_t'(sh_pll);
    OFF_TRAP_DEST: return word_t'(sh_trap);
    OFF_IRQ7_SRC:  return word_t'(sh_irq7);
    OFF_IRQ8_SRC:  return word_t'(sh_irq8);
    default:       return '0;
  endcase
endfunction

function automatic word_t cfg_word(logic en, logic oneshot, logic irqen);
  word_t w;
  w = '0;
  w[TIM_CFG_EN]      = en;
  w[TIM_CFG_ONESHOT] = oneshot;
  w[TIM_CFG_IRQEN]   = irqen;
  return w;
endfunction

task automatic check_word(input string what, input word_t exp, input word_t act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    fail_now();
  end
endtask

task automatic check_gpio(input string what, input gpio_t exp, input gpio_t act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    fail_now();
  end
endtask

task automatic check_irq(input string what, input irq_vec_t exp, input irq_vec_t act);
  if (act !== exp) begin
    $display("ERROR %s %s: expected %b, actual %b", test_name, what, exp, act);
    fail_now();
  end
endtask

`endif

// ==== tb_soc_periph.sv ====
// soc peripheral testbench
`timescale 1ns/1ns

module tb_soc_periph import soc_periph_pkg::*; ();

  localparam int MEM_WORDS    = 32768;
  localparam int TIMER_W      = 32;
  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 16;
  localparam int ACCESS_LIMIT = 8;
  localparam int RAM_N        = 12;
  localparam int GPIO_WR      = 4;
  localparam int GPIO_IN_RD   = 4;
  localparam int HOLD         = 4;
  localparam int TOGGLES      = 6;
  localparam int ONESHOT_N    = 20;
  localparam int PERIOD_R     = 6;
  localparam int PERIOD_W     = 70;
  // bus accesses per test, one to six
  localparam int ACCESSES = 2 * RAM_N + 4 * (GPIO_WR + 1) + GPIO_IN_RD + 16 + 8 + 10 + 18;
  localparam int TIMER_WAIT = ONESHOT_N + 2 + PERIOD_W;
  localparam int MARGIN = RESET_CYCLES + 8 * HOLD + 4 * TOGGLES + 100;
  localparam int WATCHDOG_CYCLES = 4 * ACCESSES + TIMER_WAIT + MARGIN;

  localparam reg_off_t SYS_OFFS [8] = '{OFF_GPIO, OFF_GPIO_OEB, OFF_GPIO_PU, OFF_GPIO_PD,
                                        OFF_PLL_DEST, OFF_TRAP_DEST, OFF_IRQ7_SRC,
                                        OFF_IRQ8_SRC};

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  mem_valid, mem_ready;
  word_t                 mem_addr, mem_wdata, mem_rdata;
  strb_t                 mem_wstrb, ram_wstrb;
  logic [RAM_ADDR_W-1:0] ram_addr;
  word_t                 ram_wdata, ram_rdata;
  gpio_t                 gpio_in, gpio_out, gpio_outenb, gpio_pullupb, gpio_pulldownb;
  logic                  trap, clk_ext_sel;
  logic [MFGR_ID_W-1:0]  mfgr_id;
  logic [PROD_ID_W-1:0]  prod_id;
  logic [MASK_REV_W-1:0] mask_rev;
  irq_vec_t              irq;

  word_t     ram [MEM_WORDS];
  word_t     ram_shadow [int];
  gpio_t     sh_gpio, sh_oeb, sh_pu, sh_pd;
  pad_dest_t sh_pll, sh_trap;
  irq_src_t  sh_irq7, sh_irq8;
  string     test_name;
  logic      chk_en;

  task automatic fail_now();
    $display("=== FAIL ===");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_soc_periph_checks.svh"

  always #(HALF_PERIOD) clk = ~clk;

  soc_periph_top #(
    .MEM_WORDS(MEM_WORDS),
    .TIMER_W  (TIMER_W)
  ) i_dut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .mem_valid_i      (mem_valid),
    .mem_ready_o      (mem_ready),
    .mem_addr_i       (mem_addr),
    .mem_wdata_i      (mem_wdata),
    .mem_wstrb_i      (mem_wstrb),
    .mem_rdata_o      (mem_rdata),
    .ram_wstrb_o      (ram_wstrb),
    .ram_addr_o       (ram_addr),
    .ram_wdata_o      (ram_wdata),
    .ram_rdata_i      (ram_rdata),
    .gpio_out_o       (gpio_out),
    .gpio_in_i        (gpio_in),
    .gpio_outenb_o    (gpio_outenb),
    .gpio_pullupb_o   (gpio_pullupb),
    .gpio_pulldownb_o (gpio_pulldownb),
    .trap_i           (trap),
    .clk_ext_sel_i    (clk_ext_sel),
    .mfgr_id_i        (mfgr_id),
    .prod_id_i        (prod_id),
    .mask_rev_i       (mask_rev),
    .irq_o            (irq)
  );

  // sram model with registered read
  always @(posedge clk) begin
    ram_rdata <= ram[ram_addr];
    for (int b = 0; b < 4; b++) begin
      if (ram_wstrb[b]) ram[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * 2 * HALF_PERIOD);
    $display("run timed out after %0d cycles", WATCHDOG_CYCLES);
    fail_now();
  end

  task automatic compare_pads();
    if (chk_en && !mem_valid) begin
      check_gpio("gpio_out", pad_model(PAD_OUT, clk, trap), gpio_out);
      check_gpio("gpio_outenb", pad_model(PAD_OEB, clk, trap), gpio_outenb);
      check_gpio("gpio_pullupb", pad_model(PAD_PU, clk, trap), gpio_pullupb);
      check_gpio("gpio_pulldownb", pad_model(PAD_PD, clk, trap), gpio_pulldownb);
      check_irq("irq", irq_model(1'b0, 1'b0), irq);
    end
  endtask

  // pads checked in the middle of both clock phases
  always begin
    @(posedge clk);
    #(HALF_PERIOD / 2);
    compare_pads();
    @(negedge clk);
    #(HALF_PERIOD / 2);
    compare_pads();
  end

  // one idle cycle before each access, returns on the ready cycle
  task automatic bus_access(input word_t addr, input word_t wdata, input strb_t wstrb,
                            output word_t rdata);
    int cycles;
    cycles = 0;
    @(negedge clk);
    mem_addr  = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    mem_valid = 1'b1;
    do begin
      @(negedge clk);
      cycles++;
    end while (!mem_ready && cycles < ACCESS_LIMIT);
    if (!mem_ready) begin
      $display("no ready from address %h within %0d cycles", addr, ACCESS_LIMIT);
      fail_now();
    end else begin
      rdata     = mem_rdata;
      mem_valid = 1'b0;
      mem_wstrb = '0;
      check_word("ready latency", 32'd1, word_t'(cycles));
    end
  endtask

  task automatic write_word(input word_t addr, input word_t data, input strb_t strb);
    word_t unused;
    bus_access(addr, data, strb, unused);
  endtask

  task automatic read_check(input string what, input word_t addr, input word_t exp);
    word_t got;
    bus_access(addr, 32'h0, 4'h0, got);
    check_word(what, exp, got);
  endtask

  task automatic sys_write(input reg_off_t off, input word_t data, input strb_t strb);
    write_word(MMIO_BASE + word_t'(off), data, strb);
    note_sys_write(off, data, strb);
  endtask

  function automatic word_t tim_addr(reg_off_t base, reg_off_t off);
    return MMIO_BASE + word_t'(base) + word_t'(off);
  endfunction

  initial begin
    int    idx;
    int    cycles;
    int    pulses;
    int    exp_pulses;
    word_t data;
    strb_t strb;
    void'($urandom(87));
    rst_n       = 1'b0;
    mem_valid   = 1'b0;
    mem_addr    = '0;
    mem_wdata   = '0;
    mem_wstrb   = '0;
    ram_rdata   = '0;
    gpio_in     = '0;
    trap        = 1'b0;
    clk_ext_sel = 1'b0;
    mfgr_id     = '0;
    prod_id     = '0;
    mask_rev    = '0;
    chk_en      = 1'b0;
    reset_shadows();
    for (int i = 0; i < MEM_WORDS; i++) begin
      ram[i] = fill_pattern(i);
    end

    test_name = "reset_ram";
    repeat (4) @(negedge clk);
    check_word("ready in reset", 32'd0, word_t'(mem_ready));
    check_irq("irq in reset", '0, irq);
    check_gpio("outenb in reset", '1, gpio_outenb);
    check_gpio("out in reset", '0, gpio_out);
    repeat (RESET_CYCLES - 4) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_word("ready after reset", 32'd0, word_t'(mem_ready));
    check_word("ram strobe idle", 32'd0, word_t'(ram_wstrb));
    check_gpio("outenb after reset", pad_model(PAD_OEB, clk, trap), gpio_outenb);
    check_gpio("pullupb after reset", pad_model(PAD_PU, clk, trap), gpio_pullupb);
    check_gpio("pulldownb after reset", pad_model(PAD_PD, clk, trap), gpio_pulldownb);
    check_irq("irq after reset", irq_model(1'b0, 1'b0), irq);
    chk_en = 1'b1;
    for (int k = 0; k < RAM_N; k++) begin
      idx  = $urandom_range(MEM_WORDS - 1, 0);
      data = $urandom;
      strb = strb_t'($urandom_range(15, 1));
      write_word(word_t'(idx) << 2, data, strb);
      note_ram_write(idx, data, strb);
      read_check("ram readback", word_t'(idx) << 2, expected_ram_word(idx));
    end

    test_name = "gpio_regs";
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < GPIO_WR; k++) begin
        sys_write(reg_off_t'(4 * r), $urandom, strb_t'($urandom_range(15, 1)));
      end
      read_check("register readback", MMIO_BASE + word_t'(4 * r),
                 sys_read_model(reg_off_t'(4 * r)));
    end
    for (int k = 0; k < GPIO_IN_RD; k++) begin
      gpio_in = gpio_t'($urandom);
      read_check("gpio data readback", MMIO_BASE + OFF_GPIO, sys_read_model(OFF_GPIO));
    end

    test_name = "pad_override";
    for (int d = 1; d <= 8; d++) begin
      data = word_t'(d % 4);
      if (d <= 4) begin
        sys_write(OFF_PLL_DEST, data, 4'b0001);
        read_check("pll dest", MMIO_BASE + OFF_PLL_DEST, sys_read_model(OFF_PLL_DEST));
      end else begin
        sys_write(OFF_TRAP_DEST, data, 4'b0001);
        read_check("trap dest", MMIO_BASE + OFF_TRAP_DEST, sys_read_model(OFF_TRAP_DEST));
      end
      repeat (HOLD) begin
        @(negedge clk);
        trap = ~trap;
      end
    end

    test_name = "irq_routing";
    for (int s = 0; s < 4; s++) begin
      sys_write(OFF_IRQ7_SRC, word_t'(s), 4'b0001);
      sys_write(OFF_IRQ8_SRC, word_t'(3 - s), 4'b0001);
      repeat (TOGGLES) begin
        @(negedge clk);
        gpio_in = gpio_t'($urandom);
      end
    end

    // timer irq bits are checked here directly
    test_name = "timers";
    chk_en = 1'b0;
    write_word(tim_addr(TIM0_BASE, OFF_TIM_DAT), word_t'(ONESHOT_N), 4'hF);
    write_word(tim_addr(TIM0_BASE, OFF_TIM_VAL), word_t'(ONESHOT_N), 4'hF);
    write_word(tim_addr(TIM0_BASE, OFF_TIM_CFG), cfg_word(1'b1, 1'b1, 1'b1), 4'h1);
    cycles = 0;
    while (!irq[0] && cycles < ONESHOT_N + 8) begin
      @(negedge clk);
      cycles++;
    end
    // N decrements, then one clock to drop the enable
    check_word("oneshot delay", word_t'(ONESHOT_N + 1), word_t'(cycles));
    check_irq("oneshot irq", irq_model(1'b1, 1'b0), irq);
    read_check("oneshot val", tim_addr(TIM0_BASE, OFF_TIM_VAL), 32'h0);
    read_check("oneshot cfg", tim_addr(TIM0_BASE, OFF_TIM_CFG), cfg_word(1'b0, 1'b1, 1'b1));
    write_word(tim_addr(TIM0_BASE, OFF_TIM_CFG), cfg_word(1'b0, 1'b0, 1'b0), 4'h1);
    write_word(tim_addr(TIM1_BASE, OFF_TIM_DAT), word_t'(PERIOD_R), 4'hF);
    write_word(tim_addr(TIM1_BASE, OFF_TIM_VAL), word_t'(PERIOD_R), 4'hF);
    write_word(tim_addr(TIM1_BASE, OFF_TIM_CFG), cfg_word(1'b1, 1'b0, 1'b1), 4'h1);
    pulses = 0;
    repeat (PERIOD_W) begin
      @(negedge clk);
      if (irq[1]) pulses++;
    end
    exp_pulses = PERIOD_W / (PERIOD_R + 1);
    if (pulses + 1 < exp_pulses || pulses > exp_pulses + 1) begin
      check_word("periodic pulses", word_t'(exp_pulses), word_t'(pulses));
    end
    write_word(tim_addr(TIM1_BASE, OFF_TIM_CFG), cfg_word(1'b0, 1'b0, 1'b0), 4'h1);

    test_name = "ident_unmapped";
    chk_en = 1'b1;
    @(negedge clk);
    mfgr_id     = MFGR_ID_W'($urandom);
    prod_id     = PROD_ID_W'($urandom);
    mask_rev    = MASK_REV_W'($urandom);
    clk_ext_sel = 1'b1;
    read_check("mfgr id", MMIO_BASE + OFF_MFGR_ID, sys_read_model(OFF_MFGR_ID));
    read_check("prod id", MMIO_BASE + OFF_PROD_ID, sys_read_model(OFF_PROD_ID));
    read_check("mask rev", MMIO_BASE + OFF_MASK_REV, sys_read_model(OFF_MASK_REV));
    read_check("clk sel", MMIO_BASE + OFF_CLK_SEL, sys_read_model(OFF_CLK_SEL));
    read_check("unknown offset", MMIO_BASE + 32'h50, sys_read_model(8'h50));
    read_check("unmapped mmio", MMIO_BASE + 32'h80, 32'h0);
    read_check("unmapped high", 32'h4000_0000, 32'h0);
    // aliases of a register offset and of the timer cfg outside their windows
    write_word(32'h0400_0004, 32'hFFFF_FFFF, 4'hF);
    write_word(MMIO_BASE + 32'h74, cfg_word(1'b1, 1'b0, 1'b1), 4'hF);
    for (int k = 0; k < 8; k++) begin
      read_check("register after unmapped write", MMIO_BASE + word_t'(SYS_OFFS[k]),
                 sys_read_model(SYS_OFFS[k]));
    end
    read_check("timer after unmapped write", tim_addr(TIM1_BASE, OFF_TIM_CFG),
               cfg_word(1'b0, 1'b0, 1'b0));

    $display("=== PASS ===");
    $finish;
  end

endmodule
